//--- hdl/mmu_pkg.sv
package mmu_pkg;

    localparam int tlb_num     = 16;
    localparam int max_pending = 3;
    localparam int pend_w      = $clog2(max_pending + 1);

    typedef logic [31:0]                vaddr_t;
    typedef logic [31:0]                paddr_t;
    typedef logic [18:0]                vpn2_t;
    typedef logic [19:0]                pfn_t;
    typedef logic [7:0]                 asid_t;
    typedef logic [$clog2(tlb_num)-1:0] tlb_idx_t;
    typedef logic [31:0]                word_t;
    typedef logic [pend_w-1:0]          pend_cnt_t;

    // one half of a page pair
    typedef struct packed {
        pfn_t       pfn;
        logic [2:0] c;
        logic       d;
        logic       v;
    } tlb_page_t;

    // vpn2 in the top bits and page1 in the bottom bits
    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        op_entryhi,
        op_tlbwi,
        op_tlbr,
        op_tlbp
    } tlb_op_e;

    typedef struct packed {
        logic       valid;
        tlb_op_e    op;
        tlb_idx_t   index;
        word_t      entryhi;
        tlb_entry_t entry;
    } maint_cmd_t;

    typedef struct packed {
        word_t      entryhi;
        tlb_entry_t r_entry;
        logic       probe_found;
        tlb_idx_t   probe_index;
    } maint_rsp_t;

    typedef enum logic [1:0] {
        fault_none,
        fault_refill,
        fault_invalid,
        fault_mod
    } fault_e;

    typedef struct packed {
        logic      hit;
        tlb_page_t page;
        tlb_idx_t  index;
    } xlate_res_t;

    typedef enum logic {
        st_idle,
        st_fault
    } fsm_state_e;

endpackage

//--- hdl/tlb.sv
`timescale 1ns/1ps

module tlb (
    input  logic               clk,
    input  logic               reset,
    // translation search
    input  mmu_pkg::vpn2_t     s_vpn2,
    input  logic               s_odd,
    input  mmu_pkg::asid_t     s_asid,
    output mmu_pkg::xlate_res_t s_res,
    // probe search
    input  mmu_pkg::vpn2_t     p_vpn2,
    input  mmu_pkg::asid_t     p_asid,
    output logic               p_found,
    output mmu_pkg::tlb_idx_t  p_index,
    // indexed write and read
    input  logic               we,
    input  mmu_pkg::tlb_idx_t  w_index,
    input  mmu_pkg::tlb_entry_t w_entry,
    input  mmu_pkg::tlb_idx_t  r_index,
    output mmu_pkg::tlb_entry_t r_entry
);
    import mmu_pkg::*;

    tlb_entry_t entries [tlb_num];

    logic [tlb_num-1:0] s_match;
    logic [tlb_num-1:0] p_match;
    tlb_idx_t           s_idx;

    function automatic logic entry_match(
        input tlb_entry_t e,
        input vpn2_t      vpn2,
        input asid_t      asid
    );
        return (e.vpn2 == vpn2) && (e.g || (e.asid == asid));
    endfunction

    // lowest matching index wins
    function automatic tlb_idx_t encode(input logic [tlb_num-1:0] m);
        tlb_idx_t idx;
        idx = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = tlb_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // reset invalidates both pages of every entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_num; i++) begin
                entries[i].page0.v <= 1'b0;
                entries[i].page1.v <= 1'b0;
            end
        end else if (we) begin
            entries[w_index] <= w_entry;
        end
    end

    // parallel compare for both search ports
    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            s_match[i] = entry_match(entries[i], s_vpn2, s_asid);
            p_match[i] = entry_match(entries[i], p_vpn2, p_asid);
        end
    end

    assign s_idx = encode(s_match);

    always_comb begin
        s_res.hit   = |s_match;
        s_res.index = s_idx;
        // bit 12 of the address picks the odd page
        s_res.page  = s_odd ? entries[s_idx].page1 : entries[s_idx].page0;
    end

    assign p_found = |p_match;
    assign p_index = encode(p_match);

    assign r_entry = entries[r_index];

endmodule

//--- hdl/tlb_maint.sv
`timescale 1ns/1ps

module tlb_maint (
    input  logic                clk,
    input  logic                reset,
    input  mmu_pkg::maint_cmd_t maint,
    output mmu_pkg::maint_rsp_t maint_rsp,
    output mmu_pkg::asid_t      asid,
    output mmu_pkg::vpn2_t      p_vpn2,
    input  logic                p_found,
    input  mmu_pkg::tlb_idx_t   p_index,
    output logic                we,
    output mmu_pkg::tlb_idx_t   w_index,
    output mmu_pkg::tlb_entry_t w_entry,
    input  mmu_pkg::tlb_entry_t r_entry
);
    import mmu_pkg::*;

    word_t      entryhi;
    tlb_entry_t tlbr_entry;
    logic       probe_found;
    tlb_idx_t   probe_index;

    always_ff @(posedge clk) begin
        if (reset) begin
            entryhi     <= '0;
            probe_found <= 1'b0;
            probe_index <= '0;
        end else if (maint.valid) begin
            case (maint.op)
                op_entryhi: entryhi <= maint.entryhi;
                op_tlbp: begin
                    probe_found <= p_found;
                    probe_index <= p_index;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (maint.valid && (maint.op == op_tlbr)) begin
            tlbr_entry <= r_entry;
        end
    end

    // asid and vpn2 fields of entryhi
    assign asid   = entryhi[7:0];
    assign p_vpn2 = entryhi[31:13];

    // index is shared by the write and the read
    assign we      = maint.valid && (maint.op == op_tlbwi);
    assign w_index = maint.index;
    assign w_entry = maint.entry;

    assign maint_rsp = '{
        entryhi:     entryhi,
        r_entry:     tlbr_entry,
        probe_found: probe_found,
        probe_index: probe_index
    };

endmodule

//--- hdl/pending_count.sv
`timescale 1ns/1ps

module pending_count (
    input  logic clk,
    input  logic reset,
    input  logic inc,
    input  logic dec,
    output logic room,
    output logic empty
);
    import mmu_pkg::*;

    pend_cnt_t count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({inc, dec})
                2'b10: begin
                    if (count != pend_cnt_t'(max_pending)) begin
                        count <= count + 1'b1;
                    end
                end
                2'b01: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end
                end
                // issue and retire together leave it unchanged
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    assign room  = count < pend_cnt_t'(max_pending);
    assign empty = count == '0;

endmodule

//--- hdl/xlate_fsm.sv
`timescale 1ns/1ps

module xlate_fsm (
    input  logic                clk,
    input  logic                reset,
    // upstream sram-like port
    input  logic                up_req,
    input  logic                up_wr,
    input  logic [3:0]          up_wstrb,
    input  mmu_pkg::vaddr_t     up_addr,
    input  mmu_pkg::word_t      up_wdata,
    output logic                up_addr_ok,
    output logic                up_data_ok,
    output mmu_pkg::word_t      up_rdata,
    output mmu_pkg::fault_e     up_fault,
    // tlb search
    output mmu_pkg::vpn2_t      s_vpn2,
    output logic                s_odd,
    input  mmu_pkg::xlate_res_t s_res,
    // downstream sram-like port
    output logic                down_req,
    output logic                down_wr,
    output logic [3:0]          down_wstrb,
    output mmu_pkg::paddr_t     down_addr,
    output mmu_pkg::word_t      down_wdata,
    input  logic                down_addr_ok,
    input  logic                down_data_ok,
    input  mmu_pkg::word_t      down_rdata,
    // pending counter
    output logic                inc,
    output logic                dec,
    input  logic                room,
    input  logic                empty
);
    import mmu_pkg::*;

    fsm_state_e state;
    fsm_state_e state_next;
    fault_e     fault;
    fault_e     fault_r;
    logic       fault_accept;

    assign s_vpn2 = up_addr[31:13];
    assign s_odd  = up_addr[12];

    always_comb begin
        if (!s_res.hit) begin
            fault = fault_refill;
        end else if (!s_res.page.v) begin
            fault = fault_invalid;
        end else if (up_wr && !s_res.page.d) begin
            fault = fault_mod;
        end else begin
            fault = fault_none;
        end
    end

    // clean hit goes straight through while there is room
    assign down_req   = (state == st_idle) && up_req && (fault == fault_none) && room;
    assign down_wr    = up_wr;
    assign down_wstrb = up_wstrb;
    assign down_addr  = {s_res.page.pfn, up_addr[11:0]};
    assign down_wdata = up_wdata;

    // a fault waits until every earlier access has answered
    assign fault_accept = (state == st_idle) && up_req && (fault != fault_none) && empty;

    assign up_addr_ok = (down_req && down_addr_ok) || fault_accept;

    assign inc = down_req && down_addr_ok;
    assign dec = down_data_ok;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (fault_accept) begin
                    state_next = st_fault;
                end
            end
            st_fault: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (fault_accept) begin
            fault_r <= fault;
        end
    end

    // nothing is in flight while in st_fault
    assign up_data_ok = (state == st_fault) || down_data_ok;
    assign up_rdata   = (state == st_fault) ? '0 : down_rdata;
    assign up_fault   = (state == st_fault) ? fault_r : fault_none;

endmodule

//--- hdl/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic                clk,
    input  logic                reset,
    // upstream, from the core
    input  logic                up_req,
    input  logic                up_wr,
    input  logic [3:0]          up_wstrb,
    input  mmu_pkg::vaddr_t     up_addr,
    input  mmu_pkg::word_t      up_wdata,
    output logic                up_addr_ok,
    output logic                up_data_ok,
    output mmu_pkg::word_t      up_rdata,
    output mmu_pkg::fault_e     up_fault,
    // downstream, to memory
    output logic                down_req,
    output logic                down_wr,
    output logic [3:0]          down_wstrb,
    output mmu_pkg::paddr_t     down_addr,
    output mmu_pkg::word_t      down_wdata,
    input  logic                down_addr_ok,
    input  logic                down_data_ok,
    input  mmu_pkg::word_t      down_rdata,
    // cp0-style maintenance
    input  mmu_pkg::maint_cmd_t maint,
    output mmu_pkg::maint_rsp_t maint_rsp
);
    import mmu_pkg::*;

    asid_t      asid;
    vpn2_t      s_vpn2;
    logic       s_odd;
    xlate_res_t s_res;
    vpn2_t      p_vpn2;
    logic       p_found;
    tlb_idx_t   p_index;
    logic       we;
    tlb_idx_t   w_index;
    tlb_entry_t w_entry;
    tlb_entry_t r_entry;
    logic       inc;
    logic       dec;
    logic       room;
    logic       empty;

    tlb_maint i_maint (
        .clk      (clk),
        .reset    (reset),
        .maint    (maint),
        .maint_rsp(maint_rsp),
        .asid     (asid),
        .p_vpn2   (p_vpn2),
        .p_found  (p_found),
        .p_index  (p_index),
        .we       (we),
        .w_index  (w_index),
        .w_entry  (w_entry),
        .r_entry  (r_entry)
    );

    // tlbr reads through the same index as tlbwi
    tlb i_tlb (
        .clk    (clk),
        .reset  (reset),
        .s_vpn2 (s_vpn2),
        .s_odd  (s_odd),
        .s_asid (asid),
        .s_res  (s_res),
        .p_vpn2 (p_vpn2),
        .p_asid (asid),
        .p_found(p_found),
        .p_index(p_index),
        .we     (we),
        .w_index(w_index),
        .w_entry(w_entry),
        .r_index(w_index),
        .r_entry(r_entry)
    );

    pending_count i_pending (
        .clk  (clk),
        .reset(reset),
        .inc  (inc),
        .dec  (dec),
        .room (room),
        .empty(empty)
    );

    xlate_fsm i_fsm (
        .clk         (clk),
        .reset       (reset),
        .up_req      (up_req),
        .up_wr       (up_wr),
        .up_wstrb    (up_wstrb),
        .up_addr     (up_addr),
        .up_wdata    (up_wdata),
        .up_addr_ok  (up_addr_ok),
        .up_data_ok  (up_data_ok),
        .up_rdata    (up_rdata),
        .up_fault    (up_fault),
        .s_vpn2      (s_vpn2),
        .s_odd       (s_odd),
        .s_res       (s_res),
        .down_req    (down_req),
        .down_wr     (down_wr),
        .down_wstrb  (down_wstrb),
        .down_addr   (down_addr),
        .down_wdata  (down_wdata),
        .down_addr_ok(down_addr_ok),
        .down_data_ok(down_data_ok),
        .down_rdata  (down_rdata),
        .inc         (inc),
        .dec         (dec),
        .room        (room),
        .empty       (empty)
    );

endmodule

//--- verif/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;
    import mmu_pkg::*;

    typedef struct packed {
        fault_e fault;
        word_t  rdata;
        paddr_t pa;
    } exp_rsp_t;

    typedef struct packed {
        logic       wr;
        logic [3:0] wstrb;
        paddr_t     addr;
        word_t      wdata;
    } down_fields_t;

    logic       clk;
    logic       reset;
    logic       up_req;
    logic       up_wr;
    logic [3:0] up_wstrb;
    vaddr_t     up_addr;
    word_t      up_wdata;
    logic       up_addr_ok;
    logic       up_data_ok;
    word_t      up_rdata;
    fault_e     up_fault;
    logic       down_req;
    logic       down_wr;
    logic [3:0] down_wstrb;
    paddr_t     down_addr;
    word_t      down_wdata;
    logic       down_addr_ok;
    logic       down_data_ok;
    word_t      down_rdata;
    maint_cmd_t maint;
    maint_rsp_t maint_rsp;

    logic [31:0]  lfsr;
    string        test_name;
    word_t        mem [256];
    word_t        ref_mem [256];
    word_t        mq[$];
    exp_rsp_t     exp_q[$];
    exp_rsp_t     cur;
    tlb_entry_t   sh [tlb_num];
    word_t        sh_hi;
    int           inflight;
    logic         accepted;
    logic         fault_due;
    logic         held;
    down_fields_t held_f;

    mmu_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_with(input string msg);
        $display("%s (test %s)", msg, test_name);
        stop_run();
    endtask

    task automatic expect_eq(input string what, input logic [77:0] exp, input logic [77:0] act);
        assert (exp === act) else begin
            $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act);
            stop_run();
        end
    endtask

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], take_bit()};
        end
        return r;
    endfunction

    // vpn2 0x106 and 0x107 are never mapped
    function automatic vaddr_t rand_addr();
        return {19'h100 + 19'(rand_bits(3)), rand_bits(1) != 0, 2'b00, 8'(rand_bits(8)), 2'b00};
    endfunction

    function automatic tlb_entry_t make_entry(input int i);
        tlb_entry_t e;
        e.vpn2  = 19'h100 + 19'(i);
        e.asid  = 8'h11;
        e.g     = (i == 3);
        e.page0 = '{pfn: 20'h80 + 20'(2 * i), c: 3'(i), d: 1'b1, v: (i != 4)};
        e.page1 = '{pfn: 20'h81 + 20'(2 * i), c: 3'(i + 1), d: (i != 2), v: 1'b1};
        return e;
    endfunction

    function automatic tlb_entry_t blank_entry(input int i);
        tlb_entry_t e;
        e      = '0;
        e.vpn2 = 19'h70000 | 19'(i);
        e.asid = 8'hff;
        return e;
    endfunction

    function automatic void lookup(input vpn2_t vpn2, input asid_t asid,
                                   output logic found, output tlb_idx_t idx);
        found = 1'b0;
        idx   = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (sh[i].vpn2 == vpn2 && (sh[i].g || sh[i].asid == asid)) begin
                found = 1'b1;
                idx   = tlb_idx_t'(i);
            end
        end
    endfunction

    // memory side driven from the lfsr on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        up_req       = 1'b0;
        maint        = '0;
        down_addr_ok = take_bit() | take_bit();
        down_data_ok = (mq.size() > 0) && take_bit();
        down_rdata   = down_data_ok ? mq[0] : '0;
    endtask

    // sample once the outputs have settled after the falling edge
    task automatic settle();
        exp_rsp_t e;
        #10;
        if (!up_req) begin
            assert (!up_addr_ok && !down_req) else fail_with("handshake raised without a request");
        end
        if (up_req && cur.fault != fault_none) begin
            assert (!down_req) else fail_with("down_req raised for a faulting request");
        end
        if (held) begin
            assert (down_req && held_f === {down_wr, down_wstrb, down_addr, down_wdata})
                else fail_with("downstream request changed while stalled");
        end
        held   = down_req && !down_addr_ok;
        held_f = {down_wr, down_wstrb, down_addr, down_wdata};
        if (fault_due) begin
            assert (up_data_ok) else fail_with("fault response not one cycle after acceptance");
        end
        fault_due = 1'b0;
        if (up_data_ok) begin
            assert (exp_q.size() > 0) else fail_with("up_data_ok without an accepted request");
            e = exp_q.pop_front();
            expect_eq("up_fault", e.fault, up_fault);
            expect_eq("up_rdata", e.rdata, up_rdata);
        end
        if (up_req && up_addr_ok) begin
            exp_q.push_back(cur);
            fault_due = (cur.fault != fault_none);
            accepted  = 1'b1;
        end
        if (down_req && down_addr_ok) begin
            expect_eq("down_addr", cur.pa, down_addr);
            if (down_wr) begin
                // only the enabled bytes are written
                for (int b = 0; b < 4; b++) begin
                    if (down_wstrb[b]) begin
                        mem[down_addr[9:2]][8*b +: 8] = down_wdata[8*b +: 8];
                    end
                end
                mq.push_back('0);
            end else begin
                mq.push_back(mem[down_addr[9:2]]);
            end
            inflight++;
        end
        if (down_data_ok) begin
            void'(mq.pop_front());
            inflight--;
        end
        assert (inflight <= max_pending) else fail_with("more than three transactions in flight");
    endtask

    task automatic access(input logic wr, input vaddr_t va, input word_t wd);
        logic      found;
        tlb_idx_t  idx;
        tlb_page_t pg;
        int        t;
        lookup(va[31:13], sh_hi[7:0], found, idx);
        pg        = va[12] ? sh[idx].page1 : sh[idx].page0;
        cur.pa    = {pg.pfn, va[11:0]};
        cur.rdata = '0;
        if (!found) begin
            cur.fault = fault_refill;
        end else if (!pg.v) begin
            cur.fault = fault_invalid;
        end else if (wr && !pg.d) begin
            cur.fault = fault_mod;
        end else begin
            cur.fault = fault_none;
            if (wr) begin
                ref_mem[cur.pa[9:2]] = wd;
            end else begin
                cur.rdata = ref_mem[cur.pa[9:2]];
            end
        end
        accepted = 1'b0;
        for (t = 0; t < 100 && !accepted; t++) begin
            next_cycle();
            up_req   = 1'b1;
            up_wr    = wr;
            up_wstrb = wr ? 4'hf : 4'h0;
            up_addr  = va;
            up_wdata = wd;
            settle();
        end
        if (!accepted) begin
            fail_with("timeout waiting for up_addr_ok");
        end
    endtask

    task automatic drain();
        int t;
        for (t = 0; t < 300 && exp_q.size() > 0; t++) begin
            next_cycle();
            settle();
        end
        if (exp_q.size() > 0) begin
            fail_with("timeout waiting for outstanding up_data_ok");
        end
    endtask

    // result is visible one cycle after the command
    task automatic maint_op(input tlb_op_e op, input int idx, input word_t hi, input tlb_entry_t e);
        next_cycle();
        maint.valid   = 1'b1;
        maint.op      = op;
        maint.index   = tlb_idx_t'(idx);
        maint.entryhi = hi;
        maint.entry   = e;
        settle();
        if (op == op_entryhi) begin
            sh_hi = hi;
        end
        if (op == op_tlbwi) begin
            sh[idx] = e;
        end
        next_cycle();
        settle();
    endtask

    task automatic probe_check(input word_t hi);
        logic     found;
        tlb_idx_t idx;
        maint_op(op_entryhi, 0, hi, '0);
        maint_op(op_tlbp, 0, '0, '0);
        lookup(hi[31:13], hi[7:0], found, idx);
        expect_eq("entryhi", hi, maint_rsp.entryhi);
        expect_eq("probe_found", found, maint_rsp.probe_found);
        if (found) begin
            expect_eq("probe_index", idx, maint_rsp.probe_index);
        end
    endtask

    initial begin
        reset        = 1'b1;
        up_req       = 1'b0;
        up_wr        = 1'b0;
        up_wstrb     = '0;
        up_addr      = '0;
        up_wdata     = '0;
        down_addr_ok = 1'b0;
        down_data_ok = 1'b0;
        down_rdata   = '0;
        maint        = '0;
        lfsr         = 32'h2a7e_6872;
        sh_hi        = '0;
        inflight     = 0;
        fault_due    = 1'b0;
        held         = 1'b0;
        cur          = '0;
        test_name    = "reset";
        // distinct pattern per word
        for (int i = 0; i < 256; i++) begin
            mem[i]     = {8'hc3, 8'(i), ~8'(i), 8'(i) ^ 8'h5a};
            ref_mem[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (5) begin
            next_cycle();
            settle();
        end
        expect_eq("entryhi", '0, maint_rsp.entryhi);

        // entries hold only cleared valid bits after reset
        for (int i = 0; i < tlb_num; i++) begin
            maint_op(op_tlbwi, i, '0, blank_entry(i));
        end
        test_name = "refill_after_reset";
        repeat (6) access(take_bit(), rand_addr(), rand_bits(32));
        drain();

        test_name = "tlbwi_tlbr";
        for (int i = 0; i < 6; i++) begin
            maint_op(op_tlbwi, i, '0, make_entry(i));
        end
        for (int i = 0; i < 6; i++) begin
            maint_op(op_tlbr, i, '0, '0);
            expect_eq("r_entry", sh[i], maint_rsp.r_entry);
        end

        test_name = "tlbp";
        probe_check({19'h102, 5'd0, 8'h11});
        probe_check({19'h102, 5'd0, 8'h22});
        probe_check({19'h103, 5'd0, 8'h55});
        probe_check({19'h1ff, 5'd0, 8'h11});
        maint_op(op_entryhi, 0, {19'h100, 5'd0, 8'h11}, '0);

        test_name = "load_store";
        for (int k = 0; k < 6; k++) begin
            access(1'b1, {19'h100 + 19'(k), k[0], 2'b00, 10'(k * 8)}, rand_bits(32));
            access(1'b0, {19'h100 + 19'(k), k[0], 2'b00, 10'(k * 8)}, '0);
        end
        drain();

        test_name = "faults";
        access(1'b0, {19'h1ff, 13'h0}, '0);
        access(1'b0, {19'h104, 1'b0, 12'h010}, '0);
        access(1'b1, {19'h102, 1'b1, 12'h020}, 32'h1234_5678);
        drain();

        test_name = "stress";
        repeat (80) access(take_bit(), rand_addr(), rand_bits(32));
        drain();

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- mmu.f
hdl/mmu_pkg.sv
hdl/tlb.sv
hdl/tlb_maint.sv
hdl/pending_count.sv
hdl/xlate_fsm.sv
hdl/mmu_top.sv
verif/mmu_tb.sv
